// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_mem_subsystem
FILELIST  := files.f

OBJDIR  := obj_dir
SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(OBJDIR)

// File: files.f
hdl/mem_pkg.sv
hdl/addr_dispatch.sv
hdl/line_buffer.sv
hdl/cbus_to_axi.sv
hdl/sramx_to_axi.sv
hdl/axi_arbiter.sv
hdl/mem_subsystem_top.sv
verification/axi_mem_model.sv
verification/tb_mem_subsystem.sv

// File: hdl/addr_dispatch.sv
// address dispatcher with kseg translation and uncached path ownership
`default_nettype none

module addr_dispatch (
    input  logic                  aclk,
    input  logic                  reset,
    input  mem_pkg::sramx_req_t   inst_req,
    input  mem_pkg::sramx_req_t   data_req,
    output mem_pkg::sramx_resp_t  inst_resp,
    output mem_pkg::sramx_resp_t  data_resp,
    output mem_pkg::sramx_req_t   icache_req,
    output mem_pkg::sramx_req_t   dcache_req,
    output mem_pkg::sramx_req_t   uncached_req,
    input  mem_pkg::sramx_resp_t  icache_resp,
    input  mem_pkg::sramx_resp_t  dcache_resp,
    input  mem_pkg::sramx_resp_t  uncached_resp
);
    mem_pkg::word_t inst_paddr, data_paddr;
    logic inst_unc, data_unc;
    logic unc_busy, unc_owner_data;
    logic unc_to_data;

    // kseg0 and kseg1 lose their segment bits, the rest maps one to one
    assign inst_paddr = (inst_req.addr[31:30] == 2'b10) ? (inst_req.addr & mem_pkg::PHYS_MASK)
                                                        : inst_req.addr;
    assign data_paddr = (data_req.addr[31:30] == 2'b10) ? (data_req.addr & mem_pkg::PHYS_MASK)
                                                        : data_req.addr;
    assign inst_unc = (inst_req.addr & ~mem_pkg::PHYS_MASK) == mem_pkg::KSEG1_BASE;
    assign data_unc = (data_req.addr & ~mem_pkg::PHYS_MASK) == mem_pkg::KSEG1_BASE;

    // owner is frozen while busy, otherwise data port wins
    assign unc_to_data = unc_busy ? unc_owner_data : (data_req.req && data_unc);

    always_comb begin
        icache_req      = inst_req;
        icache_req.addr = inst_paddr;
        icache_req.req  = inst_req.req && !inst_unc;

        dcache_req      = data_req;
        dcache_req.addr = data_paddr;
        dcache_req.req  = data_req.req && !data_unc;

        uncached_req      = unc_to_data ? data_req : inst_req;
        uncached_req.addr = unc_to_data ? data_paddr : inst_paddr;
        uncached_req.req  = unc_to_data ? (data_req.req && data_unc)
                                        : (inst_req.req && inst_unc);
    end

    // merge uncached responses into the owning port
    always_comb begin
        inst_resp = icache_resp;
        data_resp = dcache_resp;
        if (unc_to_data) begin
            data_resp.addr_ok = dcache_resp.addr_ok || uncached_resp.addr_ok;
            data_resp.data_ok = dcache_resp.data_ok || uncached_resp.data_ok;
            if (uncached_resp.data_ok)
                data_resp.rdata = uncached_resp.rdata;
        end else begin
            inst_resp.addr_ok = icache_resp.addr_ok || uncached_resp.addr_ok;
            inst_resp.data_ok = icache_resp.data_ok || uncached_resp.data_ok;
            if (uncached_resp.data_ok)
                inst_resp.rdata = uncached_resp.rdata;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            unc_busy       <= 1'b0;
            unc_owner_data <= 1'b0;
        end else if (uncached_resp.addr_ok && !uncached_resp.data_ok) begin
            unc_busy       <= 1'b1;
            unc_owner_data <= unc_to_data;
        end else if (uncached_resp.data_ok) begin
            unc_busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/axi_arbiter.sv
// fixed-priority three-master AXI3 arbiter, one transaction at a time
`default_nettype none

module axi_arbiter (
    input  logic                aclk,
    input  logic                reset,
    input  mem_pkg::axi_req_t   m_req [3],
    output mem_pkg::axi_resp_t  m_resp [3],
    output mem_pkg::axi_req_t   s_req,
    input  mem_pkg::axi_resp_t  s_resp
);
    logic busy;
    logic [1:0] grant, pick;
    logic [2:0] want;
    logic done;

    // uncached first, then data, then instruction
    always_comb begin
        for (int i = 0; i < 3; i++)
            want[i] = m_req[i].arvalid || m_req[i].awvalid;
        if (want[2])
            pick = 2'd2;
        else if (want[1])
            pick = 2'd1;
        else
            pick = 2'd0;
    end

    // transaction ends on last R beat or on B handshake
    assign done = busy && ((s_resp.rvalid && s_resp.rlast && s_req.rready)
                        || (s_resp.bvalid && s_req.bready));

    always_comb begin
        s_req = '0;
        for (int i = 0; i < 3; i++)
            m_resp[i] = '0;
        if (busy) begin
            s_req         = m_req[grant];
            m_resp[grant] = s_resp;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            busy  <= 1'b0;
            grant <= 2'd0;
        end else if (!busy && |want) begin
            busy  <= 1'b1;
            grant <= pick;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cbus_to_axi.sv
// cache bus line transfer to one AXI3 incrementing burst
`default_nettype none

module cbus_to_axi #(
    parameter int               LINE_WORDS = 4,
    parameter mem_pkg::axi_id_t ID         = '0
) (
    input  logic                 aclk,
    input  logic                 reset,
    input  mem_pkg::cbus_req_t   cbus_req,
    output mem_pkg::cbus_resp_t  cbus_resp,
    output mem_pkg::axi_req_t    axi_req,
    input  mem_pkg::axi_resp_t   axi_resp
);
    localparam int BEAT_W = $clog2(LINE_WORDS);

    typedef enum logic [2:0] {IDLE, RD_ADDR, RD_DATA, WR_ADDR, WR_DATA, WR_RESP} state_t;

    state_t state;
    logic [BEAT_W-1:0] beat;
    logic last_beat;

    assign last_beat = beat == BEAT_W'(LINE_WORDS - 1);

    always_comb begin
        axi_req         = '0;
        axi_req.arid    = ID;
        axi_req.araddr  = cbus_req.addr;
        axi_req.arlen   = cbus_req.len;
        axi_req.arsize  = 3'd2;
        axi_req.arburst = 2'b01;
        axi_req.arvalid = state == RD_ADDR;
        axi_req.rready  = state == RD_DATA;
        axi_req.awid    = ID;
        axi_req.awaddr  = cbus_req.addr;
        axi_req.awlen   = cbus_req.len;
        axi_req.awsize  = 3'd2;
        axi_req.awburst = 2'b01;
        axi_req.awvalid = state == WR_ADDR;
        axi_req.wid     = ID;
        axi_req.wdata   = cbus_req.wdata;
        axi_req.wstrb   = 4'hf;
        axi_req.wlast   = last_beat;
        axi_req.wvalid  = state == WR_DATA;
        axi_req.bready  = state == WR_RESP;
    end

    // one okay per R beat or W handshake
    assign cbus_resp.okay  = (state == RD_DATA && axi_resp.rvalid)
                          || (state == WR_DATA && axi_resp.wready);
    assign cbus_resp.last  = (state == RD_DATA) ? axi_resp.rlast : last_beat;
    assign cbus_resp.rdata = axi_resp.rdata;

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= IDLE;
            beat  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    beat <= '0;
                    if (cbus_req.valid)
                        state <= cbus_req.is_write ? WR_ADDR : RD_ADDR;
                end
                RD_ADDR: if (axi_resp.arready) state <= RD_DATA;
                RD_DATA: if (axi_resp.rvalid && axi_resp.rlast) state <= IDLE;
                WR_ADDR: if (axi_resp.awready) state <= WR_DATA;
                WR_DATA: begin
                    if (axi_resp.wready) begin
                        beat <= beat + 1'b1;
                        if (last_beat)
                            state <= WR_RESP;
                    end
                end
                WR_RESP: if (axi_resp.bvalid) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/line_buffer.sv
// single-line cache with hit service, dirty write-back and line refill FSM
`default_nettype none

module line_buffer #(
    parameter int LINE_WORDS = 4
) (
    input  logic                  aclk,
    input  logic                  reset,
    input  mem_pkg::sramx_req_t   sramx_req,
    output mem_pkg::sramx_resp_t  sramx_resp,
    output mem_pkg::cbus_req_t    cbus_req,
    input  mem_pkg::cbus_resp_t   cbus_resp
);
    localparam int OFS_W = $clog2(LINE_WORDS);
    localparam int TAG_W = 30 - OFS_W;

    typedef enum logic [1:0] {IDLE, WRITE_BACK, REFILL} state_t;

    state_t state;
    mem_pkg::word_t line [LINE_WORDS];
    logic [TAG_W-1:0] tag, req_tag;
    logic [OFS_W-1:0] beat, req_idx;
    logic valid, dirty, hit;
    logic [3:0] strb;
    logic [31:0] lane_mask;
    mem_pkg::word_t merged, rdata_q;
    logic data_ok_q;

    assign req_tag = sramx_req.addr[31 -: TAG_W];
    assign req_idx = sramx_req.addr[2 +: OFS_W];
    assign hit     = valid && (tag == req_tag);

    // store data comes right aligned and shifts to the addressed bytes
    always_comb begin
        strb = mem_pkg::byte_strb(sramx_req.size, sramx_req.addr[1:0]);
        for (int i = 0; i < 4; i++)
            lane_mask[8*i +: 8] = {8{strb[i]}};
        merged = (line[req_idx] & ~lane_mask)
               | ((sramx_req.wdata << {sramx_req.addr[1:0], 3'b000}) & lane_mask);
    end

    assign sramx_resp.addr_ok = (state == IDLE) && sramx_req.req && hit;
    assign sramx_resp.data_ok = data_ok_q;
    assign sramx_resp.rdata   = rdata_q;

    assign cbus_req.valid    = state != IDLE;
    assign cbus_req.is_write = state == WRITE_BACK;
    assign cbus_req.addr     = (state == WRITE_BACK) ? {tag, {(OFS_W + 2){1'b0}}}
                                                     : {req_tag, {(OFS_W + 2){1'b0}}};
    assign cbus_req.len      = 4'(LINE_WORDS - 1);
    assign cbus_req.wdata    = line[beat];

    always_ff @(posedge aclk) begin
        if (reset) begin
            state     <= IDLE;
            valid     <= 1'b0;
            dirty     <= 1'b0;
            beat      <= '0;
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= sramx_resp.addr_ok;
            case (state)
                IDLE: begin
                    beat <= '0;
                    if (sramx_req.req && !hit)
                        state <= (valid && dirty) ? WRITE_BACK : REFILL;
                    else if (sramx_resp.addr_ok && sramx_req.wr)
                        dirty <= 1'b1;
                end
                WRITE_BACK: begin
                    if (cbus_resp.okay) begin
                        beat <= beat + 1'b1;
                        if (cbus_resp.last) begin
                            state <= REFILL;
                            dirty <= 1'b0;
                        end
                    end
                end
                REFILL: begin
                    if (cbus_resp.okay) begin
                        beat <= beat + 1'b1;
                        if (cbus_resp.last) begin
                            state <= IDLE;
                            valid <= 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // line data and tag
    always_ff @(posedge aclk) begin
        rdata_q <= line[req_idx];
        if (state == REFILL && cbus_resp.okay) begin
            line[beat] <= cbus_resp.rdata;
            if (cbus_resp.last)
                tag <= req_tag;
        end
        if (sramx_resp.addr_ok && sramx_req.wr)
            line[req_idx] <= merged;
    end

endmodule

`default_nettype wire

// File: hdl/mem_pkg.sv
// word, processor port, cache bus and AXI3 types, segment constants, byte strobe helper
`default_nettype none

package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  axi_id_t;

    // top three address bits pick the segment
    localparam word_t PHYS_MASK  = 32'h1fff_ffff;
    localparam word_t KSEG1_BASE = 32'ha000_0000;

    typedef struct packed {
        logic       req;
        logic       wr;
        logic [1:0] size;
        word_t      addr;
        word_t      wdata;
    } sramx_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t rdata;
    } sramx_resp_t;

    typedef struct packed {
        logic       valid;
        logic       is_write;
        word_t      addr;
        logic [3:0] len;
        word_t      wdata;
    } cbus_req_t;

    typedef struct packed {
        logic  okay;
        logic  last;
        word_t rdata;
    } cbus_resp_t;

    typedef struct packed {
        axi_id_t    arid;
        word_t      araddr;
        logic [3:0] arlen;
        logic [2:0] arsize;
        logic [1:0] arburst;
        logic       arvalid;
        logic       rready;
        axi_id_t    awid;
        word_t      awaddr;
        logic [3:0] awlen;
        logic [2:0] awsize;
        logic [1:0] awburst;
        logic       awvalid;
        axi_id_t    wid;
        word_t      wdata;
        logic [3:0] wstrb;
        logic       wlast;
        logic       wvalid;
        logic       bready;
    } axi_req_t;

    typedef struct packed {
        logic    arready;
        axi_id_t rid;
        word_t   rdata;
        logic    rlast;
        logic    rvalid;
        logic    awready;
        logic    wready;
        axi_id_t bid;
        logic    bvalid;
    } axi_resp_t;

    // lanes written by a byte, half or word access at the given offset
    function automatic logic [3:0] byte_strb(input logic [1:0] size, input logic [1:0] ofs);
        case (size)
            2'd0:    return 4'b0001 << ofs;
            2'd1:    return 4'b0011 << ofs;
            default: return 4'b1111;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: hdl/mem_subsystem_top.sv
// memory subsystem top with dispatcher, line buffers, AXI converters and arbiter
`default_nettype none

module mem_subsystem_top #(
    parameter int LINE_WORDS = 4
) (
    input  logic                  aclk,
    input  logic                  reset,
    input  mem_pkg::sramx_req_t   inst_req,
    input  mem_pkg::sramx_req_t   data_req,
    output mem_pkg::sramx_resp_t  inst_resp,
    output mem_pkg::sramx_resp_t  data_resp,
    output mem_pkg::axi_req_t     axi_req,
    input  mem_pkg::axi_resp_t    axi_resp
);
    mem_pkg::sramx_req_t  icache_req, dcache_req, uncached_req;
    mem_pkg::sramx_resp_t icache_resp, dcache_resp, uncached_resp;
    mem_pkg::cbus_req_t   icbus_req, dcbus_req;
    mem_pkg::cbus_resp_t  icbus_resp, dcbus_resp;

    // master 0 instruction, 1 data, 2 uncached
    mem_pkg::axi_req_t  m_axi_req [3];
    mem_pkg::axi_resp_t m_axi_resp [3];

    addr_dispatch dispatch0 (
        .aclk, .reset,
        .inst_req, .data_req, .inst_resp, .data_resp,
        .icache_req, .dcache_req, .uncached_req,
        .icache_resp, .dcache_resp, .uncached_resp
    );

    line_buffer #(.LINE_WORDS(LINE_WORDS)) ibuf0 (
        .aclk, .reset,
        .sramx_req(icache_req), .sramx_resp(icache_resp),
        .cbus_req(icbus_req), .cbus_resp(icbus_resp)
    );

    line_buffer #(.LINE_WORDS(LINE_WORDS)) dbuf0 (
        .aclk, .reset,
        .sramx_req(dcache_req), .sramx_resp(dcache_resp),
        .cbus_req(dcbus_req), .cbus_resp(dcbus_resp)
    );

    cbus_to_axi #(.LINE_WORDS(LINE_WORDS), .ID(4'd0)) icbus_axi0 (
        .aclk, .reset,
        .cbus_req(icbus_req), .cbus_resp(icbus_resp),
        .axi_req(m_axi_req[0]), .axi_resp(m_axi_resp[0])
    );

    cbus_to_axi #(.LINE_WORDS(LINE_WORDS), .ID(4'd1)) dcbus_axi0 (
        .aclk, .reset,
        .cbus_req(dcbus_req), .cbus_resp(dcbus_resp),
        .axi_req(m_axi_req[1]), .axi_resp(m_axi_resp[1])
    );

    sramx_to_axi uncached_axi0 (
        .aclk, .reset,
        .sramx_req(uncached_req), .sramx_resp(uncached_resp),
        .axi_req(m_axi_req[2]), .axi_resp(m_axi_resp[2])
    );

    axi_arbiter arb0 (
        .aclk, .reset,
        .m_req(m_axi_req), .m_resp(m_axi_resp),
        .s_req(axi_req), .s_resp(axi_resp)
    );

endmodule

`default_nettype wire

// File: hdl/sramx_to_axi.sv
// uncached SRAM-like request to a single-beat AXI3 read or write
`default_nettype none

module sramx_to_axi (
    input  logic                  aclk,
    input  logic                  reset,
    input  mem_pkg::sramx_req_t   sramx_req,
    output mem_pkg::sramx_resp_t  sramx_resp,
    output mem_pkg::axi_req_t     axi_req,
    input  mem_pkg::axi_resp_t    axi_resp
);
    typedef enum logic [2:0] {IDLE, RD_ADDR, RD_DATA, WR_ADDR, WR_DATA, WR_RESP} state_t;

    state_t state;
    mem_pkg::word_t addr_q, wdata_q;
    logic [1:0] size_q;
    logic [3:0] strb_q;

    assign sramx_resp.addr_ok = (state == IDLE) && sramx_req.req;
    assign sramx_resp.data_ok = (state == RD_DATA && axi_resp.rvalid && axi_resp.rlast)
                             || (state == WR_RESP && axi_resp.bvalid);
    assign sramx_resp.rdata   = axi_resp.rdata;

    always_comb begin
        axi_req         = '0;
        axi_req.arid    = 4'd2;
        axi_req.araddr  = addr_q;
        axi_req.arsize  = {1'b0, size_q};
        axi_req.arburst = 2'b01;
        axi_req.arvalid = state == RD_ADDR;
        axi_req.rready  = state == RD_DATA;
        axi_req.awid    = 4'd2;
        axi_req.awaddr  = addr_q;
        axi_req.awsize  = {1'b0, size_q};
        axi_req.awburst = 2'b01;
        axi_req.awvalid = state == WR_ADDR;
        axi_req.wid     = 4'd2;
        axi_req.wdata   = wdata_q;
        axi_req.wstrb   = strb_q;
        axi_req.wlast   = 1'b1;
        axi_req.wvalid  = state == WR_DATA;
        axi_req.bready  = state == WR_RESP;
    end

    // request captured on accept, data moved onto its byte lanes
    always_ff @(posedge aclk) begin
        if (sramx_resp.addr_ok) begin
            addr_q  <= sramx_req.addr;
            size_q  <= sramx_req.size;
            wdata_q <= sramx_req.wdata << {sramx_req.addr[1:0], 3'b000};
            strb_q  <= mem_pkg::byte_strb(sramx_req.size, sramx_req.addr[1:0]);
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (sramx_req.req) state <= sramx_req.wr ? WR_ADDR : RD_ADDR;
                RD_ADDR: if (axi_resp.arready) state <= RD_DATA;
                RD_DATA: if (axi_resp.rvalid && axi_resp.rlast) state <= IDLE;
                WR_ADDR: if (axi_resp.awready) state <= WR_DATA;
                WR_DATA: if (axi_resp.wready) state <= WR_RESP;
                WR_RESP: if (axi_resp.bvalid) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verification/axi_mem_model.sv
// AXI3 slave memory with LFSR ready back-pressure, id checks and transaction counters
`default_nettype none

module axi_mem_model (
    input  logic                aclk,
    input  logic                reset,
    input  mem_pkg::axi_req_t   axi_req,
    output mem_pkg::axi_resp_t  axi_resp,
    output int                  ar_count,
    output int                  aw_count,
    output int                  ar_by_id [3],
    output int                  last_arlen,
    output logic                proto_err
);
    typedef enum logic [1:0] {IDLE, READ, WRITE, RESP} state_t;

    mem_pkg::word_t mem [4096];
    logic [31:0] lfsr;
    logic go;
    state_t state;
    mem_pkg::axi_id_t id;
    logic [11:0] idx;
    logic [3:0] left;

    // taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one bit per cycle, the active channel is ready or waits
    assign go = lfsr[31];

    always_ff @(posedge aclk) begin
        if (reset) begin
            for (int i = 0; i < 4096; i++)
                mem[i] <= 32'(i << 2) ^ 32'h5a5a_0000;
            lfsr       <= 32'hbd65_aa72;
            axi_resp   <= '0;
            state      <= IDLE;
            id         <= '0;
            idx        <= '0;
            left       <= '0;
            ar_count   <= 0;
            aw_count   <= 0;
            ar_by_id   <= '{0, 0, 0};
            last_arlen <= 0;
            proto_err  <= 1'b0;
        end else begin
            lfsr <= lfsr_step(lfsr);
            case (state)
                IDLE: begin
                    if (axi_req.arvalid && axi_resp.arready) begin
                        axi_resp.arready <= 1'b0;
                        id         <= axi_req.arid;
                        idx        <= axi_req.araddr[13:2];
                        left       <= axi_req.arlen;
                        last_arlen <= int'(axi_req.arlen);
                        ar_count   <= ar_count + 1;
                        if (axi_req.arid < 4'd3)
                            ar_by_id[axi_req.arid[1:0]] <= ar_by_id[axi_req.arid[1:0]] + 1;
                        else
                            proto_err <= 1'b1;
                        state <= READ;
                    end else if (axi_req.awvalid && axi_resp.awready) begin
                        axi_resp.awready <= 1'b0;
                        id       <= axi_req.awid;
                        idx      <= axi_req.awaddr[13:2];
                        left     <= axi_req.awlen;
                        aw_count <= aw_count + 1;
                        state    <= WRITE;
                    end else begin
                        axi_resp.arready <= axi_req.arvalid && go;
                        axi_resp.awready <= axi_req.awvalid && go;
                    end
                end
                READ: begin
                    if (axi_resp.rvalid && axi_req.rready) begin
                        axi_resp.rvalid <= 1'b0;
                        idx  <= idx + 1'b1;
                        left <= left - 1'b1;
                        if (axi_resp.rlast)
                            state <= IDLE;
                    end else if (!axi_resp.rvalid && go) begin
                        axi_resp.rvalid <= 1'b1;
                        axi_resp.rdata  <= mem[idx];
                        axi_resp.rlast  <= left == 4'd0;
                        axi_resp.rid    <= id;
                    end
                end
                WRITE: begin
                    if (axi_resp.wready && axi_req.wvalid) begin
                        axi_resp.wready <= 1'b0;
                        for (int i = 0; i < 4; i++)
                            if (axi_req.wstrb[i])
                                mem[idx][8*i +: 8] <= axi_req.wdata[8*i +: 8];
                        // W beats carry the burst id and the last flag on the final beat
                        if (axi_req.wid != id || axi_req.wlast != (left == 4'd0))
                            proto_err <= 1'b1;
                        idx  <= idx + 1'b1;
                        left <= left - 1'b1;
                        if (axi_req.wlast)
                            state <= RESP;
                    end else begin
                        axi_resp.wready <= axi_req.wvalid && go;
                    end
                end
                RESP: begin
                    if (axi_resp.bvalid && axi_req.bready) begin
                        axi_resp.bvalid <= 1'b0;
                        state <= IDLE;
                    end else if (!axi_resp.bvalid && go) begin
                        axi_resp.bvalid <= 1'b1;
                        axi_resp.bid    <= id;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_mem_subsystem.sv
// memory subsystem testbench with clock, reset, directed tests, compare tasks and timeout
`default_nettype none

module tb_mem_subsystem;
    localparam int LINE_WORDS  = 4;
    localparam int DRIVE_DELAY = 5;
    // about twenty accesses, each well under a few hundred cycles with back-pressure
    localparam int TIMEOUT_CYCLES = 20000;

    logic aclk;
    logic reset;
    mem_pkg::sramx_req_t  inst_req, data_req;
    mem_pkg::sramx_resp_t inst_resp, data_resp;
    mem_pkg::axi_req_t    axi_req;
    mem_pkg::axi_resp_t   axi_resp;
    int ar_count, aw_count, last_arlen;
    int ar_by_id [3];
    logic proto_err;
    int cycle_count = 0;
    mem_pkg::word_t ref_mem [4096];

    mem_subsystem_top #(.LINE_WORDS(LINE_WORDS)) dut0 (
        .aclk, .reset, .inst_req, .data_req, .inst_resp, .data_resp, .axi_req, .axi_resp
    );

    axi_mem_model mem0 (
        .aclk, .reset, .axi_req, .axi_resp,
        .ar_count, .aw_count, .ar_by_id, .last_arlen, .proto_err
    );

    always #50 aclk = ~aclk;

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input mem_pkg::word_t got,
                              input mem_pkg::word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %s: got %0h, expected %0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    always @(negedge aclk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end else if (proto_err) begin
            $display("memory model saw a wrong AXI id or a misplaced write last flag");
            abort_run();
        end
    end

    // expected memory after right aligned store data lands on the addressed bytes
    task automatic ref_store(input mem_pkg::word_t addr, input logic [1:0] size,
                             input mem_pkg::word_t wdata);
        int nbytes;
        int ofs;
        nbytes = 1 << size;
        ofs = int'(addr[1:0]);
        for (int i = 0; i < 4; i++)
            if (i >= ofs && i < ofs + nbytes)
                ref_mem[addr[13:2]][8*i +: 8] = wdata[8*(i - ofs) +: 8];
    endtask

    task automatic drive_port(input int port, input mem_pkg::sramx_req_t r);
        if (port == 0)
            inst_req = r;
        else
            data_req = r;
    endtask

    function automatic mem_pkg::sramx_resp_t port_resp(input int port);
        return (port == 0) ? inst_resp : data_resp;
    endfunction

    // one SRAM-like access, outputs sampled at the falling edge
    task automatic port_access(input int port, input logic wr, input logic [1:0] size,
                               input mem_pkg::word_t addr, input mem_pkg::word_t wdata,
                               output mem_pkg::word_t rdata);
        mem_pkg::sramx_req_t r;
        mem_pkg::sramx_resp_t s;
        logic done;
        r.req = 1'b1;
        r.wr = wr;
        r.size = size;
        r.addr = addr;
        r.wdata = wdata;
        @(posedge aclk);
        #DRIVE_DELAY;
        drive_port(port, r);
        do begin
            @(negedge aclk);
            s = port_resp(port);
        end while (!s.addr_ok);
        done = s.data_ok;
        rdata = s.rdata;
        @(posedge aclk);
        #DRIVE_DELAY;
        drive_port(port, '0);
        while (!done) begin
            @(negedge aclk);
            s = port_resp(port);
            done = s.data_ok;
            rdata = s.rdata;
        end
    endtask

    task automatic read_and_check(input int port, input mem_pkg::word_t addr);
        mem_pkg::word_t rdata;
        port_access(port, 1'b0, 2'd2, addr, '0, rdata);
        check_word(port == 0 ? "inst_resp.rdata" : "data_resp.rdata", rdata,
                   ref_mem[addr[13:2]]);
    endtask

    task automatic store(input int port, input logic [1:0] size, input mem_pkg::word_t addr,
                         input mem_pkg::word_t wdata);
        mem_pkg::word_t ignored;
        port_access(port, 1'b1, size, addr, wdata, ignored);
        ref_store(addr, size, wdata);
    endtask

    task automatic test_reset_state();
        @(negedge aclk);
        check_flag("inst_resp.addr_ok", inst_resp.addr_ok, 1'b0);
        check_flag("inst_resp.data_ok", inst_resp.data_ok, 1'b0);
        check_flag("data_resp.addr_ok", data_resp.addr_ok, 1'b0);
        check_flag("data_resp.data_ok", data_resp.data_ok, 1'b0);
        check_flag("axi_req.arvalid", axi_req.arvalid, 1'b0);
        check_flag("axi_req.awvalid", axi_req.awvalid, 1'b0);
        check_flag("axi_req.wvalid", axi_req.wvalid, 1'b0);
    endtask

    task automatic test_uncached_read();
        int ar0;
        int aw0;
        ar0 = ar_count;
        aw0 = aw_count;
        read_and_check(1, 32'ha000_0100);
        check_count("ar_count", ar_count - ar0, 1);
        check_count("arlen", last_arlen, 0);
        check_count("aw_count", aw_count - aw0, 0);
    endtask

    task automatic test_uncached_partial();
        int aw0;
        aw0 = aw_count;
        store(1, 2'd0, 32'ha000_0205, 32'h0000_00ab);
        store(1, 2'd1, 32'ha000_0206, 32'h0000_cdef);
        read_and_check(1, 32'ha000_0204);
        check_count("aw_count", aw_count - aw0, 2);
    endtask

    task automatic test_line_fill();
        int ar0;
        ar0 = ar_count;
        read_and_check(1, 32'h8000_0400);
        check_count("ar_count", ar_count - ar0, 1);
        check_count("arlen", last_arlen, LINE_WORDS - 1);
        for (int i = 1; i < LINE_WORDS; i++)
            read_and_check(1, 32'h8000_0400 + 4 * i);
        check_count("ar_count", ar_count - ar0, 1);
    endtask

    task automatic test_write_back();
        int aw0;
        aw0 = aw_count;
        // line at 0x400 is still held from the fill test
        store(1, 2'd2, 32'h8000_0408, 32'h1234_5678);
        store(1, 2'd0, 32'h8000_040d, 32'h0000_0099);
        check_count("aw_count", aw_count - aw0, 0);
        read_and_check(1, 32'h8000_0800);
        check_count("aw_count", aw_count - aw0, 1);
        read_and_check(1, 32'ha000_0408);
        read_and_check(1, 32'ha000_040c);
    endtask

    task automatic test_concurrent();
        int base [3];
        base = ar_by_id;
        fork
            read_and_check(0, 32'h8000_1000);
            read_and_check(1, 32'h8000_1410);
        join
        check_count("ar_by_id[0]", ar_by_id[0] - base[0], 1);
        check_count("ar_by_id[1]", ar_by_id[1] - base[1], 1);
        // both ports on the uncached path, data goes first
        fork
            read_and_check(0, 32'ha000_0204);
            read_and_check(1, 32'ha000_0100);
        join
        check_count("ar_by_id[2]", ar_by_id[2] - base[2], 2);
        // instruction hit beside a data refill
        fork
            read_and_check(0, 32'h8000_100c);
            read_and_check(1, 32'h8000_1800);
        join
        check_count("ar_by_id[0]", ar_by_id[0] - base[0], 1);
        check_count("ar_by_id[1]", ar_by_id[1] - base[1], 2);
    endtask

    initial begin
        aclk = 1'b0;
        reset = 1'b1;
        inst_req = '0;
        data_req = '0;
        for (int i = 0; i < 4096; i++)
            ref_mem[i] = 32'(i << 2) ^ 32'h5a5a_0000;
        repeat (8) @(posedge aclk);
        #DRIVE_DELAY;
        reset = 1'b0;
        test_reset_state();
        test_uncached_read();
        test_uncached_partial();
        test_line_fill();
        test_write_back();
        test_concurrent();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
